//--- hw/big_pkg.sv
`default_nettype none

package big_pkg;

	// controller states with S1 out of reset
	typedef enum logic [2:0] {
		S1,
		S2,
		S3,
		S4,
		S5,
		S6,
		S7
	} state_t;

	// {x18, x17}
	typedef enum logic [1:0] {
		MODE_NONE = 2'b00,
		MODE_A    = 2'b01, // x17 only
		MODE_B    = 2'b10, // x18 only
		MODE_BOTH = 2'b11
	} mode_t;

	// one action per arc named after its target state
	typedef enum logic [2:0] {
		ACT_NONE,
		ACT_S2,
		ACT_S3,
		ACT_S4,
		ACT_S5,
		ACT_S6,
		ACT_S7
	} act_t;

	localparam int COND_W = 15; // x1..x12, x14..x16
	typedef logic [COND_W-1:0] cond_t;

	localparam int C_X1  = 0;
	localparam int C_X2  = 1;
	localparam int C_X3  = 2;
	localparam int C_X4  = 3;
	localparam int C_X5  = 4;
	localparam int C_X6  = 5;
	localparam int C_X7  = 6;
	localparam int C_X8  = 7;
	localparam int C_X9  = 8;
	localparam int C_X10 = 9;
	localparam int C_X11 = 10;
	localparam int C_X12 = 11;
	localparam int C_X14 = 12;
	localparam int C_X15 = 13;
	localparam int C_X16 = 14;

	localparam int CMD_W = 18;
	typedef logic [CMD_W-1:0] cmd_t;

	// bit positions of the kept command lines
	localparam int Y1  = 0;
	localparam int Y2  = 1;
	localparam int Y3  = 2;
	localparam int Y4  = 3;
	localparam int Y5  = 4;
	localparam int Y6  = 5;
	localparam int Y7  = 6;
	localparam int Y8  = 7;
	localparam int Y10 = 8;
	localparam int Y11 = 9;
	localparam int Y13 = 10;
	localparam int Y16 = 11;
	localparam int Y18 = 12;
	localparam int Y22 = 13;
	localparam int Y24 = 14;
	localparam int Y26 = 15;
	localparam int Y27 = 16;
	localparam int Y28 = 17;

endpackage

`default_nettype wire

//--- hw/in_capture.sv
`timescale 1ns/1ps
`default_nettype none

module in_capture (
	input  logic           rst, // clock
	input  logic           clk, // async reset, active low
	input  big_pkg::cond_t cond,
	input  logic           x17,
	input  logic           x18,
	output big_pkg::cond_t cond_q,
	output big_pkg::mode_t mode_q
);

	import big_pkg::*;

	mode_t mode_d;

	always_comb
	begin
		case ({x18, x17})
			2'b11:   mode_d = MODE_BOTH;
			2'b01:   mode_d = MODE_A;
			2'b10:   mode_d = MODE_B;
			default: mode_d = MODE_NONE;
		endcase
	end

	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			cond_q <= '0;
			mode_q <= MODE_NONE;
		end
		else
		begin
			cond_q <= cond;
			mode_q <= mode_d;
		end
	end

endmodule

`default_nettype wire

//--- hw/fsm_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fsm_ctrl (
	input  logic           rst,
	input  logic           clk,
	input  big_pkg::cond_t cond_q,
	input  big_pkg::mode_t mode_q,
	output big_pkg::act_t  act
);

	import big_pkg::*;

	state_t state_q;
	state_t nxt_state;
	logic   quiet; // arc or self loop without outputs

	// S1 branch under x17 only or x18 only with x15 low
	function automatic state_t s1_low(cond_t c);
		if (!c[C_X1])
			return S4;
		else if (!c[C_X2])
			return S2;
		else if (c[C_X3])
			return c[C_X4] ? S1 : S5;
		else if (c[C_X4])
			return c[C_X5] ? S6 : S7;
		else
			return S3;
	endfunction

	function automatic act_t act_for(state_t s);
		case (s)
			S2:      return ACT_S2;
			S3:      return ACT_S3;
			S4:      return ACT_S4;
			S5:      return ACT_S5;
			S6:      return ACT_S6;
			S7:      return ACT_S7;
			default: return ACT_NONE; // nothing ever asserts on the way into S1
		endcase
	endfunction

	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
			state_q <= S1;
		else
			state_q <= nxt_state;
	end

	// arcs into the removed states fall back to S1
	always_comb
	begin
		nxt_state = state_q;
		quiet = 1'b0;
		case (state_q)
			S1:
				case (mode_q)
					MODE_BOTH:
						if (cond_q[C_X1])
							nxt_state = S2;
						else
							nxt_state = cond_q[C_X2] ? S3 : S4;
					MODE_A:
						if (!cond_q[C_X15])
							nxt_state = s1_low(cond_q);
						else if (cond_q[C_X1])
							nxt_state = cond_q[C_X10] ? S4 : S5;
						else
							nxt_state = cond_q[C_X6] ? S2 : S3;
					MODE_B:
						if (!cond_q[C_X15])
							nxt_state = s1_low(cond_q);
						else if (cond_q[C_X1])
							nxt_state = S3;
						else
							nxt_state = cond_q[C_X4] ? S4 : S5;
					MODE_NONE:
						nxt_state = S2;
				endcase
			S2:
				case (mode_q)
					MODE_BOTH:
						nxt_state = S1; // every arc here hit a removed state
					MODE_A:
						if (cond_q[C_X11])
							nxt_state = S2; // self loop that still asserts
						else
							nxt_state = cond_q[C_X16] ? S3 : S1;
					MODE_B:
						nxt_state = S3;
					MODE_NONE:
						if (cond_q[C_X15])
						begin
							if (!cond_q[C_X1])
								nxt_state = S7;
							else if (cond_q[C_X2])
								nxt_state = S3;
							else if (cond_q[C_X3])
								nxt_state = S4;
							else
								quiet = 1'b1;
						end
						else if (cond_q[C_X1])
						begin
							if (cond_q[C_X2])
								nxt_state = cond_q[C_X3] ? S7 : S1;
							else
								nxt_state = S5;
						end
						else
							nxt_state = cond_q[C_X2] ? S3 : S4;
				endcase
			S3:
				case (mode_q)
					MODE_BOTH:
						if (cond_q[C_X1])
							nxt_state = S5;
						else
							nxt_state = cond_q[C_X3] ? S6 : S7;
					MODE_A:
						nxt_state = S1;
					MODE_B:
						if (cond_q[C_X15])
							nxt_state = cond_q[C_X5] ? S4 : S1;
						else
							nxt_state = S7;
					MODE_NONE:
						if (cond_q[C_X15])
							nxt_state = S5;
						else if (cond_q[C_X5] && !cond_q[C_X3])
							nxt_state = S1;
						else
							nxt_state = S7;
				endcase
			S4:
				case (mode_q)
					MODE_BOTH:
						nxt_state = S1;
					MODE_A:
						nxt_state = cond_q[C_X12] ? S2 : S3;
					MODE_B:
						if (cond_q[C_X15])
							nxt_state = S1; // x9 either way
						else if (cond_q[C_X3])
						begin
							if (cond_q[C_X4])
								quiet = 1'b1;
							else
								nxt_state = S5;
						end
						else if (cond_q[C_X4])
							nxt_state = cond_q[C_X5] ? S6 : S7;
						else
							nxt_state = S3;
					MODE_NONE:
						if (cond_q[C_X15])
							nxt_state = cond_q[C_X2] ? S6 : S1;
						else
							nxt_state = S6;
				endcase
			S5:
				case (mode_q)
					MODE_BOTH:
						if (cond_q[C_X1])
							nxt_state = S5;
						else
							nxt_state = cond_q[C_X3] ? S6 : S7;
					MODE_A:
						nxt_state = S4;
					MODE_B:
						if (cond_q[C_X15])
							nxt_state = cond_q[C_X2] ? S1 : S6;
						else
							nxt_state = S6;
					MODE_NONE:
						if (cond_q[C_X15])
							nxt_state = cond_q[C_X2] ? S6 : S1;
						else if (!cond_q[C_X1])
							nxt_state = S6;
						else
							nxt_state = cond_q[C_X3] ? S7 : S1;
				endcase
			S6:
				if (mode_q == MODE_A)
					quiet = 1'b1;
				else
					nxt_state = S1;
			S7:
				case (mode_q)
					MODE_BOTH:
						nxt_state = S1;
					MODE_A:
						if (cond_q[C_X5])
							quiet = 1'b1;
						else
							nxt_state = cond_q[C_X14] ? S3 : S1;
					MODE_B:
						nxt_state = cond_q[C_X15] ? S6 : S1;
					MODE_NONE:
						if (!cond_q[C_X15])
							quiet = 1'b1;
						else if (!cond_q[C_X4])
							nxt_state = S5;
						else if (cond_q[C_X1])
							quiet = 1'b1;
						else
							nxt_state = S1;
				endcase
			default:
				nxt_state = S1;
		endcase
	end

	assign act = quiet ? ACT_NONE : act_for(nxt_state);

endmodule

`default_nettype wire

//--- hw/act_decode.sv
`timescale 1ns/1ps
`default_nettype none

module act_decode (
	input  logic          rst,
	input  logic          clk,
	input  big_pkg::act_t act,
	output big_pkg::cmd_t cmd
);

	import big_pkg::*;

	cmd_t cmd_d;

	always_comb
	begin
		cmd_d = '0;
		case (act)
			ACT_S2:
			begin
				cmd_d[Y4] = 1'b1;
				cmd_d[Y6] = 1'b1;
				cmd_d[Y7] = 1'b1;
			end
			ACT_S3:
			begin
				cmd_d[Y8]  = 1'b1;
				cmd_d[Y10] = 1'b1;
				cmd_d[Y26] = 1'b1;
				cmd_d[Y27] = 1'b1;
			end
			ACT_S4:
			begin
				cmd_d[Y16] = 1'b1;
				cmd_d[Y22] = 1'b1;
				cmd_d[Y24] = 1'b1;
			end
			ACT_S5:
			begin
				cmd_d[Y1] = 1'b1;
				cmd_d[Y2] = 1'b1;
				cmd_d[Y3] = 1'b1;
				cmd_d[Y5] = 1'b1;
			end
			ACT_S6:
			begin
				cmd_d[Y11] = 1'b1;
				cmd_d[Y18] = 1'b1;
			end
			ACT_S7:
			begin
				cmd_d[Y7]  = 1'b1; // shared with ACT_S2
				cmd_d[Y13] = 1'b1;
				cmd_d[Y28] = 1'b1;
			end
			default: cmd_d = '0;
		endcase
	end

	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
			cmd <= '0;
		else
			cmd <= cmd_d;
	end

endmodule

`default_nettype wire

//--- hw/big_top.sv
`timescale 1ns/1ps
`default_nettype none

module big_top (
	input  logic           rst, // clock
	input  logic           clk, // active-low async reset
	input  big_pkg::cond_t cond,
	input  logic           x17,
	input  logic           x18,
	output big_pkg::cmd_t  cmd
);

	import big_pkg::*;

	cond_t cond_q;
	mode_t mode_q;
	act_t  act;

	// inputs reach cmd two edges later through capture, Mealy step and decode
	in_capture u_in_capture (
		.rst    (rst),
		.clk    (clk),
		.cond   (cond),
		.x17    (x17),
		.x18    (x18),
		.cond_q (cond_q),
		.mode_q (mode_q)
	);

	fsm_ctrl u_fsm_ctrl (
		.rst    (rst),
		.clk    (clk),
		.cond_q (cond_q),
		.mode_q (mode_q),
		.act    (act)
	);

	act_decode u_act_decode (
		.rst (rst),
		.clk (clk),
		.act (act),
		.cmd (cmd)
	);

endmodule

`default_nettype wire

//--- tests/big_ref.svh
`ifndef BIG_REF_SVH
`define BIG_REF_SVH

// one-hot helper for building expected command words
function automatic cmd_t y_line(input int pos);
	return cmd_t'(1) << pos;
endfunction

// next state and action of one arc with x17/x18 taken raw
function automatic void ref_step(input state_t s, input cond_t c, input logic a17,
		input logic a18, output state_t ns, output act_t act);
	logic hold; // self loop that asserts nothing
	ns = s;
	hold = 1'b0;
	case (s)
		S1:
			if (a17 && a18)
				ns = c[C_X1] ? S2 : (c[C_X2] ? S3 : S4);
			else if (!a17 && !a18)
				ns = S2;
			else if (!c[C_X15])
			begin
				if (!c[C_X1])
					ns = S4;
				else if (!c[C_X2])
					ns = S2;
				else if (c[C_X3])
					ns = c[C_X4] ? S1 : S5;
				else
					ns = c[C_X4] ? (c[C_X5] ? S6 : S7) : S3;
			end
			else if (a17)
				ns = c[C_X1] ? (c[C_X10] ? S4 : S5) : (c[C_X6] ? S2 : S3);
			else
				ns = c[C_X1] ? S3 : (c[C_X4] ? S4 : S5);
		S2:
			if (a17 && a18)
				ns = S1; // dropped targets
			else if (a17)
				ns = c[C_X11] ? S2 : (c[C_X16] ? S3 : S1);
			else if (a18)
				ns = S3;
			else if (c[C_X15])
			begin
				if (!c[C_X1])
					ns = S7;
				else if (c[C_X2])
					ns = S3;
				else if (c[C_X3])
					ns = S4;
				else
					hold = 1'b1;
			end
			else if (c[C_X1])
				ns = c[C_X2] ? (c[C_X3] ? S7 : S1) : S5;
			else
				ns = c[C_X2] ? S3 : S4;
		S3:
			if (a17 && a18)
				ns = c[C_X1] ? S5 : (c[C_X3] ? S6 : S7);
			else if (a17)
				ns = S1;
			else if (a18)
				ns = c[C_X15] ? (c[C_X5] ? S4 : S1) : S7;
			else if (c[C_X15])
				ns = S5;
			else
				ns = (c[C_X5] && !c[C_X3]) ? S1 : S7;
		S4:
			if (a17 && a18)
				ns = S1;
			else if (a17)
				ns = c[C_X12] ? S2 : S3;
			else if (!a18)
				ns = (c[C_X15] && !c[C_X2]) ? S1 : S6;
			else if (c[C_X15])
				ns = S1;
			else if (c[C_X3] && c[C_X4])
				hold = 1'b1;
			else if (c[C_X3])
				ns = S5;
			else if (c[C_X4])
				ns = c[C_X5] ? S6 : S7;
			else
				ns = S3;
		S5:
			if (a17 && a18)
				ns = c[C_X1] ? S5 : (c[C_X3] ? S6 : S7);
			else if (a17)
				ns = S4;
			else if (a18)
				ns = (c[C_X15] && c[C_X2]) ? S1 : S6;
			else if (c[C_X15])
				ns = c[C_X2] ? S6 : S1;
			else if (!c[C_X1])
				ns = S6;
			else
				ns = c[C_X3] ? S7 : S1;
		S6:
			if (a17 && !a18)
				hold = 1'b1;
			else
				ns = S1;
		S7:
			if (a17 && a18)
				ns = S1;
			else if (a17)
			begin
				if (c[C_X5])
					hold = 1'b1;
				else
					ns = c[C_X14] ? S3 : S1;
			end
			else if (a18)
				ns = c[C_X15] ? S6 : S1;
			else if (!c[C_X15] || (c[C_X4] && c[C_X1]))
				hold = 1'b1;
			else
				ns = c[C_X4] ? S1 : S5;
		default:
			ns = S1;
	endcase
	if (hold)
		act = ACT_NONE;
	else
		case (ns)
			S2:      act = ACT_S2;
			S3:      act = ACT_S3;
			S4:      act = ACT_S4;
			S5:      act = ACT_S5;
			S6:      act = ACT_S6;
			S7:      act = ACT_S7;
			default: act = ACT_NONE; // arcs into S1 are silent
		endcase
endfunction

// command lines of each action
function automatic cmd_t ref_cmd(input act_t act);
	case (act)
		ACT_S2:  return y_line(Y4) | y_line(Y6) | y_line(Y7);
		ACT_S3:  return y_line(Y8) | y_line(Y10) | y_line(Y26) | y_line(Y27);
		ACT_S4:  return y_line(Y16) | y_line(Y22) | y_line(Y24);
		ACT_S5:  return y_line(Y1) | y_line(Y2) | y_line(Y3) | y_line(Y5);
		ACT_S6:  return y_line(Y11) | y_line(Y18);
		ACT_S7:  return y_line(Y7) | y_line(Y13) | y_line(Y28);
		default: return '0;
	endcase
endfunction

`endif

//--- tests/tb_big.sv
`timescale 1ns/1ps
`default_nettype none

module tb_big;

	import big_pkg::*;

	`include "big_ref.svh"

	localparam int CLK_NS    = 8;
	localparam int RESET_CYC = 4;
	localparam int DIR_CYC   = 18;
	localparam int RAND_CYC  = 2000;
	localparam int DRAIN_CYC = 4;

	logic  rst = 1'b0; // clock
	logic  clk;        // active-low async reset
	cond_t cond;
	logic  x17;
	logic  x18;
	cmd_t  cmd;

	logic [31:0] lfsr;

	// directed expectation that travels with its inputs
	logic   hint_on;
	string  hint_name;
	act_t   hint_act;
	state_t hint_tgt;

	// model pipeline
	cond_t  cap_cond;
	logic   cap_x17;
	logic   cap_x18;
	logic   cap_hint;
	string  cap_name;
	act_t   cap_act;
	state_t cap_tgt;
	state_t m_state;
	state_t m_next;
	act_t   m_act;
	cmd_t   exp_cmd;
	string  exp_name;
	logic   hand_on;
	string  hand_name;
	cmd_t   hand_cmd;

	always #(CLK_NS / 2) rst = ~rst;

	big_top DUT (
		.rst  (rst),
		.clk  (clk),
		.cond (cond),
		.x17  (x17),
		.x18  (x18),
		.cmd  (cmd)
	);

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_cmd(input string name, input cmd_t exp, input cmd_t got);
		if (got !== exp)
			fail_now($sformatf("[FAIL] %s: expected %h, got %h", name, exp, got));
	endtask

	task automatic check_state_reached(input string name, input state_t exp,
			input state_t got);
		if (got !== exp)
			fail_now($sformatf("[FAIL] %s: expected state %s, got %s",
				name, exp.name(), got.name()));
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic cond_t cond_bit(input int pos);
		return cond_t'(1) << pos;
	endfunction

	// one arc per cycle driven on the falling edge
	task automatic take_arc(input string name, input cond_t c, input logic a17,
			input logic a18, input act_t act_exp, input state_t tgt);
		cond = c;
		x17 = a17;
		x18 = a18;
		hint_on = 1'b1;
		hint_name = name;
		hint_act = act_exp;
		hint_tgt = tgt;
		@(negedge rst);
	endtask

	always @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			m_state = S1;
			cap_cond = '0;
			cap_x17 = 1'b0;
			cap_x18 = 1'b0;
			cap_hint = 1'b0;
			exp_cmd = '0;
			exp_name = "reset";
			hand_on = 1'b0;
		end
		else
		begin
			// arc from inputs captured one edge ago
			ref_step(m_state, cap_cond, cap_x17, cap_x18, m_next, m_act);
			if (cap_hint)
				check_state_reached(cap_name, cap_tgt, m_next);
			exp_cmd = ref_cmd(m_act);
			exp_name = "ref model";
			hand_on = cap_hint;
			hand_name = cap_name;
			hand_cmd = ref_cmd(cap_act);
			m_state = m_next;
			cap_cond = cond;
			cap_x17 = x17;
			cap_x18 = x18;
			cap_hint = hint_on;
			cap_name = hint_name;
			cap_act = hint_act;
			cap_tgt = hint_tgt;
		end
	end

	// cmd only moves on the rising edge
	always @(negedge rst)
	begin
		check_cmd(exp_name, exp_cmd, cmd);
		if (hand_on)
			check_cmd(hand_name, hand_cmd, cmd);
	end

	initial
	begin
		#((RESET_CYC + DIR_CYC + RAND_CYC + DRAIN_CYC + 20) * CLK_NS);
		fail_now("timeout: the test sequence did not finish in time");
	end

	initial
	begin
		logic [31:0] bits;
		clk = 1'b0;
		cond = '0;
		x17 = 1'b0;
		x18 = 1'b0;
		hint_on = 1'b0;
		hint_name = "";
		hint_act = ACT_NONE;
		hint_tgt = S1;
		lfsr = 32'h6b14;
		repeat (RESET_CYC) @(negedge rst);
		clk = 1'b1;

		// reset capture already sends S1 to S2
		take_arc("s2 into dropped state", cond_bit(C_X4), 1, 1, ACT_NONE, S1);
		take_arc("s1 to s2", '0, 0, 0, ACT_S2, S2);
		take_arc("s2 to s3", '0, 0, 1, ACT_S3, S3);
		take_arc("s3 to s5", cond_bit(C_X1), 1, 1, ACT_S5, S5);
		take_arc("s5 to s4", '0, 1, 0, ACT_S4, S4);
		take_arc("s4 hold", cond_bit(C_X3) | cond_bit(C_X4), 0, 1, ACT_NONE, S4);
		take_arc("s4 hold again", cond_bit(C_X3) | cond_bit(C_X4), 0, 1, ACT_NONE, S4);
		take_arc("s4 to s6", '0, 0, 0, ACT_S6, S6);
		take_arc("s6 into dropped state", cond_bit(C_X7), 1, 1, ACT_NONE, S1);
		take_arc("s1 to s3", cond_bit(C_X2), 1, 1, ACT_S3, S3);
		take_arc("s3 to s7", '0, 1, 1, ACT_S7, S7);
		take_arc("s7 hold", cond_bit(C_X5), 1, 0, ACT_NONE, S7);
		take_arc("s7 hold again", cond_bit(C_X5), 1, 0, ACT_NONE, S7);
		take_arc("s7 to s3", cond_bit(C_X14), 1, 0, ACT_S3, S3);
		take_arc("s3 to s1", '0, 1, 0, ACT_NONE, S1);
		take_arc("s1 to s2 both", cond_bit(C_X1), 1, 1, ACT_S2, S2);
		take_arc("s2 self loop", cond_bit(C_X11), 1, 0, ACT_S2, S2);
		take_arc("s2 back to s1", '0, 1, 1, ACT_NONE, S1);
		hint_on = 1'b0;

		repeat (RAND_CYC)
		begin
			draw_bits(COND_W, bits);
			cond = bits[COND_W-1:0];
			draw_bits(2, bits);
			x17 = bits[0];
			x18 = bits[1];
			@(negedge rst);
		end
		repeat (DRAIN_CYC) @(negedge rst);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+tests
hw/big_pkg.sv
hw/in_capture.sv
hw/fsm_ctrl.sv
hw/act_decode.sv
hw/big_top.sv
tests/tb_big.sv

//--- Bender.yml
package:
  name: big_fsm

sources:
  - hw/big_pkg.sv
  - hw/in_capture.sv
  - hw/fsm_ctrl.sv
  - hw/act_decode.sv
  - hw/big_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_big.sv
